/* lsq_pkg.sv */
package lsq_pkg;

    localparam int XLEN     = 32;
    localparam int SQ_DEPTH = 8;
    localparam int SQ_IDX_W = 3;
    localparam int LB_DEPTH = 8;
    localparam int LB_IDX_W = 3;
    localparam int PREG_W   = 6;
    localparam int ROB_W    = 5;

    typedef logic [SQ_IDX_W-1:0] sq_ptr_t;
    typedef logic [LB_IDX_W-1:0] lb_idx_t;

    // Encoded as log2 of the byte count
    typedef enum logic [1:0] {
        BYTE = 2'd0,
        HALF = 2'd1,
        WORD = 2'd2
    } mem_size_e;

    typedef struct packed {
        sq_ptr_t          sq_idx;
        logic [XLEN-1:0]  base;
        logic [XLEN-1:0]  offset;
        logic [XLEN-1:0]  data;
        mem_size_e        size;
        logic [ROB_W-1:0] rob_idx;
    } store_resolve_t;

    typedef struct packed {
        lb_idx_t           lb_idx;
        logic [XLEN-1:0]   base;
        logic [XLEN-1:0]   offset;
        mem_size_e         size;
        logic              is_signed;
        logic [PREG_W-1:0] dest_preg;
        logic [ROB_W-1:0]  rob_idx;
    } load_resolve_t;

    typedef struct packed {
        logic             resolved;
        logic [XLEN-1:0]  addr;
        logic [XLEN-1:0]  data;
        mem_size_e        size;
        logic [ROB_W-1:0] rob_idx;
    } sq_entry_t;

    typedef sq_entry_t [SQ_DEPTH-1:0] sq_array_t;

    typedef struct packed {
        logic              resolved;
        sq_ptr_t           age;
        logic [XLEN-1:0]   addr;
        mem_size_e         size;
        logic              is_signed;
        logic [PREG_W-1:0] dest_preg;
        logic [ROB_W-1:0]  rob_idx;
    } lb_entry_t;

    typedef struct packed {
        logic [XLEN-1:0]   value;
        logic [PREG_W-1:0] dest_preg;
        logic [ROB_W-1:0]  rob_idx;
    } load_result_t;

    typedef struct packed {
        logic [XLEN-1:0]   addr;
        mem_size_e         size;
        logic              is_signed;
        logic [PREG_W-1:0] dest_preg;
        logic [ROB_W-1:0]  rob_idx;
    } cache_load_t;

    typedef struct packed {
        logic [XLEN-1:0]  addr;
        logic [XLEN-1:0]  data;
        mem_size_e        size;
        logic [ROB_W-1:0] rob_idx;
    } cache_store_t;

    // Store idx is older than a load of this age when it sits in [head, age)
    function automatic logic is_older(sq_ptr_t idx, sq_ptr_t age, sq_ptr_t head);
        sq_ptr_t idx_dist;
        sq_ptr_t age_dist;
        idx_dist = idx - head;
        age_dist = age - head;
        return idx_dist < age_dist;
    endfunction

    // One past the last byte, with a carry bit so the top of memory works
    function automatic logic [XLEN:0] access_end(logic [XLEN-1:0] addr, mem_size_e size);
        return {1'b0, addr} + ((XLEN+1)'(1) << size);
    endfunction

    function automatic logic store_covers(logic [XLEN-1:0] s_addr, mem_size_e s_size,
                                          logic [XLEN-1:0] l_addr, mem_size_e l_size);
        return (s_addr <= l_addr) &&
               (access_end(l_addr, l_size) <= access_end(s_addr, s_size));
    endfunction

    function automatic logic bytes_overlap(logic [XLEN-1:0] s_addr, mem_size_e s_size,
                                           logic [XLEN-1:0] l_addr, mem_size_e l_size);
        return ({1'b0, s_addr} < access_end(l_addr, l_size)) &&
               ({1'b0, l_addr} < access_end(s_addr, s_size));
    endfunction

endpackage

/* store_queue.sv */
`timescale 1ns/10ps

module store_queue import lsq_pkg::*; (
    input  logic           clock,
    input  logic           reset,
    input  logic           store_alloc,
    input  logic           store_resolve_valid,
    input  store_resolve_t store_resolve,
    input  logic           store_commit,
    output sq_ptr_t        sq_tail,
    output sq_ptr_t        sq_head,
    output logic           sq_full,
    output logic           sq_head_resolved,
    output logic           store_retire,
    output logic           cache_store_valid,
    output cache_store_t   cache_store,
    output sq_array_t      sq_entries,
    output sq_ptr_t        oldest_unresolved,
    output logic           all_resolved
);

    logic [SQ_IDX_W:0] count;
    sq_ptr_t           scan_idx;
    logic              scan_found;

    ////////////////////
    // Head retirement
    ////////////////////

    assign sq_head_resolved  = sq_entries[sq_head].resolved;
    assign store_retire      = store_commit && sq_head_resolved;
    assign cache_store_valid = store_retire;

    // One slot stays empty so tail never catches head
    assign sq_full = (count == SQ_DEPTH - 1);

    always_comb begin
        cache_store.addr    = sq_entries[sq_head].addr;
        cache_store.data    = sq_entries[sq_head].data;
        cache_store.size    = sq_entries[sq_head].size;
        cache_store.rob_idx = sq_entries[sq_head].rob_idx;
    end

    ////////////////////
    // Ring update
    ////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            sq_head <= '0;
            sq_tail <= '0;
            count   <= '0;
            for (int i = 0; i < SQ_DEPTH; i++) begin
                sq_entries[i].resolved <= 1'b0;
            end
        end else begin
            if (store_alloc) begin
                sq_entries[sq_tail].resolved <= 1'b0;
                sq_tail <= sq_tail + 1'b1;
            end

            // Late resolves to a finished entry are dropped
            if (store_resolve_valid && !sq_entries[store_resolve.sq_idx].resolved) begin
                sq_entries[store_resolve.sq_idx].resolved <= 1'b1;
                sq_entries[store_resolve.sq_idx].addr     <= store_resolve.base +
                                                             store_resolve.offset;
                sq_entries[store_resolve.sq_idx].data     <= store_resolve.data;
                sq_entries[store_resolve.sq_idx].size     <= store_resolve.size;
                sq_entries[store_resolve.sq_idx].rob_idx  <= store_resolve.rob_idx;
            end

            if (store_retire) begin
                sq_entries[sq_head].resolved <= 1'b0;
                sq_head <= sq_head + 1'b1;
            end

            case ({store_alloc, store_retire})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    ////////////////////
    // Oldest unresolved
    ////////////////////

    // Walk youngest to oldest so the last hit is the oldest one
    always_comb begin
        scan_idx   = sq_head;
        scan_found = 1'b0;
        for (int k = SQ_DEPTH - 1; k >= 0; k--) begin
            if (k < count && !sq_entries[sq_head + sq_ptr_t'(k)].resolved) begin
                scan_idx   = sq_head + sq_ptr_t'(k);
                scan_found = 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            oldest_unresolved <= '0;
            all_resolved      <= 1'b1;
        end else begin
            oldest_unresolved <= scan_idx;
            all_resolved      <= !scan_found;
        end
    end

    // Dispatch must stall on sq_full
    assert property (@(posedge clock) disable iff (reset) store_alloc |-> !sq_full)
        else $error("store allocated while the store queue is full");

    // A resolved head must also be a live entry of the ring
    assert property (@(posedge clock) disable iff (reset)
        cache_store_valid |-> (count != '0))
        else $error("cache store without a live resolved head entry");

endmodule

/* load_buffer.sv */
`timescale 1ns/10ps

module load_buffer import lsq_pkg::*; (
    input  logic          clock,
    input  logic          reset,
    input  logic          load_alloc,
    input  logic          load_resolve_valid,
    input  load_resolve_t load_resolve,
    input  sq_ptr_t       sq_tail,
    input  sq_ptr_t       sq_head,
    input  logic          store_retire,
    input  sq_array_t     sq_entries,
    input  sq_ptr_t       oldest_unresolved,
    input  logic          all_resolved,
    output lb_idx_t       lb_free_idx,
    output logic          lb_full,
    output logic          issue_valid,
    output lb_entry_t     issue_entry
);

    lb_entry_t           entries [LB_DEPTH];
    logic [LB_DEPTH-1:0] busy;
    logic [LB_DEPTH-1:0] eligible;
    lb_idx_t             issue_idx;

    ////////////////////
    // Free list
    ////////////////////

    assign lb_full = &busy;

    // Highest free index wins
    always_comb begin
        lb_free_idx = '0;
        for (int j = 0; j < LB_DEPTH; j++) begin
            if (!busy[j]) begin
                lb_free_idx = lb_idx_t'(j);
            end
        end
    end

    ////////////////////
    // Issue check
    ////////////////////

    always_comb begin
        for (int j = 0; j < LB_DEPTH; j++) begin
            eligible[j] = busy[j] && entries[j].resolved;

            // Some older store still has an unknown address
            if (!all_resolved && is_older(oldest_unresolved, entries[j].age, sq_head)) begin
                eligible[j] = 1'b0;
            end

            // Partial overlap needs the cache to merge, so wait for the store to drain
            for (int s = 0; s < SQ_DEPTH; s++) begin
                if (is_older(sq_ptr_t'(s), entries[j].age, sq_head) &&
                        sq_entries[s].resolved &&
                        bytes_overlap(sq_entries[s].addr, sq_entries[s].size,
                                      entries[j].addr, entries[j].size) &&
                        !store_covers(sq_entries[s].addr, sq_entries[s].size,
                                      entries[j].addr, entries[j].size)) begin
                    eligible[j] = 1'b0;
                end
            end
        end
    end

    // Lowest eligible index goes first
    always_comb begin
        issue_idx = '0;
        for (int j = LB_DEPTH - 1; j >= 0; j--) begin
            if (eligible[j]) begin
                issue_idx = lb_idx_t'(j);
            end
        end
    end

    assign issue_valid = |eligible;
    assign issue_entry = entries[issue_idx];

    ////////////////////
    // Entry update
    ////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            busy <= '0;
            for (int j = 0; j < LB_DEPTH; j++) begin
                entries[j].resolved <= 1'b0;
            end
        end else begin
            // Keep ages from falling behind the head as stores drain
            if (store_retire) begin
                for (int j = 0; j < LB_DEPTH; j++) begin
                    if (busy[j] && entries[j].age == sq_head) begin
                        entries[j].age <= sq_head + 1'b1;
                    end
                end
            end

            if (load_alloc) begin
                busy[lb_free_idx]             <= 1'b1;
                entries[lb_free_idx].resolved <= 1'b0;
                entries[lb_free_idx].age      <= sq_tail;
            end

            if (load_resolve_valid && busy[load_resolve.lb_idx] &&
                    !entries[load_resolve.lb_idx].resolved) begin
                entries[load_resolve.lb_idx].resolved  <= 1'b1;
                entries[load_resolve.lb_idx].addr      <= load_resolve.base + load_resolve.offset;
                entries[load_resolve.lb_idx].size      <= load_resolve.size;
                entries[load_resolve.lb_idx].is_signed <= load_resolve.is_signed;
                entries[load_resolve.lb_idx].dest_preg <= load_resolve.dest_preg;
                entries[load_resolve.lb_idx].rob_idx   <= load_resolve.rob_idx;
            end

            if (issue_valid) begin
                busy[issue_idx]             <= 1'b0;
                entries[issue_idx].resolved <= 1'b0;
            end
        end
    end

    assert property (@(posedge clock) disable iff (reset) load_alloc |-> !lb_full)
        else $error("load allocated while the load buffer is full");

    // Resolve packets come only for loads that dispatch has placed
    assert property (@(posedge clock) disable iff (reset)
        load_resolve_valid |-> busy[load_resolve.lb_idx])
        else $error("load resolve to a free entry");

endmodule

/* store_forward.sv */
`timescale 1ns/10ps

module store_forward import lsq_pkg::*; (
    input  logic         clock,
    input  logic         reset,
    input  logic         issue_valid,
    input  lb_entry_t    issue_entry,
    input  sq_ptr_t      sq_head,
    input  sq_array_t    sq_entries,
    output logic         result_valid,
    output load_result_t result,
    output logic         cache_load_valid,
    output cache_load_t  cache_load
);

    logic            match;
    sq_ptr_t         match_idx;
    sq_entry_t       src;
    logic [1:0]      byte_off;
    logic [XLEN-1:0] shifted;
    logic [XLEN-1:0] value;

    ////////////////////
    // Store search
    ////////////////////

    // Oldest first, so the youngest covering store is the last hit
    always_comb begin
        match     = 1'b0;
        match_idx = sq_head;
        for (int k = 0; k < SQ_DEPTH; k++) begin
            if (is_older(sq_head + sq_ptr_t'(k), issue_entry.age, sq_head) &&
                    sq_entries[sq_head + sq_ptr_t'(k)].resolved &&
                    store_covers(sq_entries[sq_head + sq_ptr_t'(k)].addr,
                                 sq_entries[sq_head + sq_ptr_t'(k)].size,
                                 issue_entry.addr, issue_entry.size)) begin
                match     = 1'b1;
                match_idx = sq_head + sq_ptr_t'(k);
            end
        end
    end

    ////////////////////
    // Byte extraction
    ////////////////////

    // A covering store is at most a word, so the offset fits in two bits
    assign src      = sq_entries[match_idx];
    assign byte_off = issue_entry.addr[1:0] - src.addr[1:0];
    assign shifted  = src.data >> {byte_off, 3'b000};

    always_comb begin
        case (issue_entry.size)
            BYTE: begin
                value = issue_entry.is_signed ? {{(XLEN-8){shifted[7]}}, shifted[7:0]}
                                              : {{(XLEN-8){1'b0}}, shifted[7:0]};
            end
            HALF: begin
                value = issue_entry.is_signed ? {{(XLEN-16){shifted[15]}}, shifted[15:0]}
                                              : {{(XLEN-16){1'b0}}, shifted[15:0]};
            end
            default: begin
                value = shifted;
            end
        endcase
    end

    ////////////////////
    // Output stage
    ////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            result_valid     <= 1'b0;
            cache_load_valid <= 1'b0;
        end else begin
            result_valid     <= issue_valid && match;
            cache_load_valid <= issue_valid && !match;
        end
    end

    always_ff @(posedge clock) begin
        result.value         <= value;
        result.dest_preg     <= issue_entry.dest_preg;
        result.rob_idx       <= issue_entry.rob_idx;
        cache_load.addr      <= issue_entry.addr;
        cache_load.size      <= issue_entry.size;
        cache_load.is_signed <= issue_entry.is_signed;
        cache_load.dest_preg <= issue_entry.dest_preg;
        cache_load.rob_idx   <= issue_entry.rob_idx;
    end

    // Only a load with a known address may reach the search
    assert property (@(posedge clock) disable iff (reset)
        issue_valid |-> issue_entry.resolved)
        else $error("load issued before its address was resolved");

endmodule

/* lsq_top.sv */
`timescale 1ns/10ps

module lsq_top import lsq_pkg::*; (
    input  logic           clock,
    input  logic           reset,
    input  logic           store_alloc,
    input  logic           store_resolve_valid,
    input  store_resolve_t store_resolve,
    input  logic           store_commit,
    input  logic           load_alloc,
    input  logic           load_resolve_valid,
    input  load_resolve_t  load_resolve,
    output sq_ptr_t        sq_tail,
    output logic           sq_full,
    output logic           sq_head_resolved,
    output logic           cache_store_valid,
    output cache_store_t   cache_store,
    output lb_idx_t        lb_free_idx,
    output logic           lb_full,
    output logic           result_valid,
    output load_result_t   result,
    output logic           cache_load_valid,
    output cache_load_t    cache_load
);

    // Store queue state seen by the load side
    sq_array_t sq_entries;
    sq_ptr_t   sq_head;
    logic      store_retire;
    sq_ptr_t   oldest_unresolved;
    logic      all_resolved;

    // Issue path into the forwarding stage
    logic      issue_valid;
    lb_entry_t issue_entry;

    store_queue store_queue0 (.*);

    load_buffer load_buffer0 (.*);

    store_forward store_forward0 (.*);

endmodule

/* lsq_clock_gen.sv */
`timescale 1ns/10ps

module lsq_clock_gen (
    output logic clock,
    output logic reset
);

    // 8 ns period
    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // Held through five rising edges, released after the fifth
    initial begin
        reset = 1'b1;
        repeat (5) @(posedge clock);
        reset <= 1'b0;
    end

endmodule

/* lsq_tb.sv */
`timescale 1ns/10ps

module lsq_tb import lsq_pkg::*; ();

    localparam int NUM_OPS = 4000;

    logic           clock;
    logic           reset;
    logic           store_alloc;
    logic           store_resolve_valid;
    store_resolve_t store_resolve;
    logic           store_commit;
    logic           load_alloc;
    logic           load_resolve_valid;
    load_resolve_t  load_resolve;
    sq_ptr_t        sq_tail;
    logic           sq_full;
    logic           sq_head_resolved;
    logic           cache_store_valid;
    cache_store_t   cache_store;
    lb_idx_t        lb_free_idx;
    logic           lb_full;
    logic           result_valid;
    load_result_t   result;
    logic           cache_load_valid;
    cache_load_t    cache_load;

    // Reference model state
    integer           seed = 32'h067e2f1e;
    sq_entry_t        st [SQ_DEPTH];
    int               st_seq [SQ_DEPTH];
    int               st_head;
    int               st_count;
    int               st_total;
    lb_entry_t        ld [LB_DEPTH];
    logic             ld_busy [LB_DEPTH];
    logic             ld_pending [LB_DEPTH];
    logic             ld_fwd [LB_DEPTH];
    logic [XLEN-1:0]  ld_value [LB_DEPTH];
    int               ld_seq [LB_DEPTH];
    logic [ROB_W-1:0] load_tag;
    logic             drain;

    lsq_clock_gen clock_gen0 (.clock(clock), .reset(reset));

    lsq_top dut0 (.*);

    ////////////////////
    // Error reporting
    ////////////////////

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic value_error(input string what, input longint got, input longint exp);
        stop_run($sformatf("FAIL at %0t ns: %s is %0h, expected %0h", $time, what, got, exp));
    endtask

    task automatic check_result(input load_result_t got, input load_result_t exp);
        if (got !== exp) begin
            stop_run($sformatf("FAIL at %0t ns: result %h/%0d/%0d, expected %h/%0d/%0d", $time,
                got.value, got.dest_preg, got.rob_idx, exp.value, exp.dest_preg, exp.rob_idx));
        end
    endtask

    task automatic check_cache_load(input cache_load_t got, input cache_load_t exp);
        if (got !== exp) begin
            stop_run($sformatf("FAIL at %0t ns: cache load %h, expected %h", $time, got, exp));
        end
    endtask

    task automatic check_cache_store(input cache_store_t got, input cache_store_t exp);
        if (got !== exp) begin
            stop_run($sformatf("FAIL at %0t ns: cache store %h, expected %h", $time, got, exp));
        end
    endtask

    ////////////////////
    // Model helpers
    ////////////////////

    function automatic int roll(input int n);
        return {$random(seed)} % n;
    endfunction

    function automatic int size_bytes(input mem_size_e size);
        case (size)
            BYTE: return 1;
            HALF: return 2;
            default: return 4;
        endcase
    endfunction

    // Naturally aligned, inside a 16 byte window so stores and loads collide often
    function automatic logic [XLEN-1:0] rand_addr(input mem_size_e size);
        return 32'h8000_0000 + (roll(16) / size_bytes(size)) * size_bytes(size);
    endfunction

    function automatic logic covers(input sq_entry_t s, input lb_entry_t l);
        return longint'(s.addr) <= longint'(l.addr) &&
               longint'(l.addr) + size_bytes(l.size) <= longint'(s.addr) + size_bytes(s.size);
    endfunction

    function automatic logic overlaps(input sq_entry_t s, input lb_entry_t l);
        return longint'(s.addr) < longint'(l.addr) + size_bytes(l.size) &&
               longint'(l.addr) < longint'(s.addr) + size_bytes(s.size);
    endfunction

    // Byte by byte copy out of the store data, then extension
    function automatic logic [XLEN-1:0] forward_value(input sq_entry_t s, input lb_entry_t l);
        int              sh;
        int              n;
        logic [XLEN-1:0] v;
        sh = int'(l.addr - s.addr);
        n  = size_bytes(l.size);
        v  = '0;
        for (int b = 0; b < n; b++) begin
            v[8*b +: 8] = s.data[8*(sh+b) +: 8];
        end
        if (l.is_signed && n < 4 && v[8*n-1]) begin
            for (int b = n; b < 4; b++) begin
                v[8*b +: 8] = 8'hff;
            end
        end
        return v;
    endfunction

    // A load waits on any older store that is unresolved or only partly covers it
    task automatic mark_eligible();
        int   idx;
        int   best;
        logic blocked;
        for (int j = 0; j < LB_DEPTH; j++) begin
            if (ld_busy[j] && ld[j].resolved && !ld_pending[j]) begin
                blocked = 1'b0;
                best    = -1;
                for (int k = 0; k < st_count; k++) begin
                    idx = (st_head + k) % SQ_DEPTH;
                    if (st_seq[idx] < ld_seq[j]) begin
                        if (!st[idx].resolved || (overlaps(st[idx], ld[j]) &&
                                                  !covers(st[idx], ld[j]))) begin
                            blocked = 1'b1;
                        end else if (covers(st[idx], ld[j])) begin
                            best = idx;
                        end
                    end
                end
                if (!blocked) begin
                    ld_pending[j] = 1'b1;
                    ld_fwd[j]     = (best >= 0);
                    if (best >= 0) begin
                        ld_value[j] = forward_value(st[best], ld[j]);
                    end
                end
            end
        end
    endtask

    ////////////////////
    // Per-cycle checks
    ////////////////////

    task automatic collect_outputs();
        load_result_t     exp_r;
        cache_load_t      exp_c;
        logic [ROB_W-1:0] rob;
        int               hit;
        if (result_valid !== 1'b0 && cache_load_valid !== 1'b0) begin
            stop_run("Result and cache load were raised together or are unknown");
        end else if (result_valid === 1'b1 || cache_load_valid === 1'b1) begin
            rob = result_valid ? result.rob_idx : cache_load.rob_idx;
            hit = -1;
            for (int j = 0; j < LB_DEPTH; j++) begin
                if (ld_busy[j] && ld_pending[j] && ld[j].rob_idx == rob) begin
                    hit = j;
                end
            end
            if (hit < 0) begin
                stop_run("A load output appeared with no eligible load waiting for it");
            end else if (ld_fwd[hit] !== result_valid) begin
                value_error("forwarded from a store", result_valid, ld_fwd[hit]);
            end else if (result_valid) begin
                exp_r.value     = ld_value[hit];
                exp_r.dest_preg = ld[hit].dest_preg;
                exp_r.rob_idx   = ld[hit].rob_idx;
                check_result(result, exp_r);
            end else begin
                exp_c.addr      = ld[hit].addr;
                exp_c.size      = ld[hit].size;
                exp_c.is_signed = ld[hit].is_signed;
                exp_c.dest_preg = ld[hit].dest_preg;
                exp_c.rob_idx   = ld[hit].rob_idx;
                check_cache_load(cache_load, exp_c);
            end
            ld_busy[hit]     = 1'b0;
            ld_pending[hit]  = 1'b0;
            ld[hit].resolved = 1'b0;
        end
    endtask

    task automatic check_state();
        lb_idx_t exp_free;
        logic    exp_full;
        exp_free = '0;
        exp_full = 1'b1;
        for (int j = 0; j < LB_DEPTH; j++) begin
            if (!ld_busy[j]) begin
                exp_free = lb_idx_t'(j);
                exp_full = 1'b0;
            end
        end
        if (sq_tail !== sq_ptr_t'((st_head + st_count) % SQ_DEPTH)) begin
            value_error("sq_tail", sq_tail, (st_head + st_count) % SQ_DEPTH);
        end
        if (sq_full !== (st_count == SQ_DEPTH - 1)) begin
            value_error("sq_full", sq_full, st_count == SQ_DEPTH - 1);
        end
        if (sq_head_resolved !== st[st_head].resolved) begin
            value_error("sq_head_resolved", sq_head_resolved, st[st_head].resolved);
        end
        if (lb_full !== exp_full) begin
            value_error("lb_full", lb_full, exp_full);
        end
        if (!exp_full && lb_free_idx !== exp_free) begin
            value_error("lb_free_idx", lb_free_idx, exp_free);
        end
    endtask

    ////////////////////
    // Stimulus and model update
    ////////////////////

    task automatic drive_cycle();
        int              ri;
        int              li;
        int              pick;
        int              tail;
        int              free_cnt;
        logic            waiting;
        logic            retire;
        lb_idx_t         new_ld;
        logic [XLEN-1:0] s_addr;
        logic [XLEN-1:0] l_addr;
        mem_size_e       size;
        cache_store_t    exp_cs;
        waiting  = 1'b0;
        free_cnt = 0;
        new_ld   = '0;
        for (int j = 0; j < LB_DEPTH; j++) begin
            waiting = waiting | (ld_busy[j] && ld_pending[j]);
            if (!ld_busy[j]) begin
                new_ld   = lb_idx_t'(j);
                free_cnt = free_cnt + 1;
            end
        end

        // Stores
        store_alloc         = !drain && st_count < SQ_DEPTH - 1 && roll(4) == 0;
        store_resolve_valid = st_count > 0 && roll(drain ? 2 : 3) == 0;
        ri     = (st_head + roll(st_count > 0 ? st_count : 1)) % SQ_DEPTH;
        size   = mem_size_e'(roll(3));
        s_addr = rand_addr(size);
        store_resolve.sq_idx  = sq_ptr_t'(ri);
        store_resolve.base    = $random(seed);
        store_resolve.offset  = s_addr - store_resolve.base;
        store_resolve.data    = $random(seed);
        store_resolve.size    = size;
        store_resolve.rob_idx = ROB_W'(roll(32));
        // No commit while a ready load still needs the current store contents
        store_commit = !waiting && st_count > 0 && roll(drain ? 2 : 4) == 0;

        // Loads
        load_alloc = !drain && free_cnt > 0 && roll(4) == 0;
        li   = -1;
        pick = roll(LB_DEPTH);
        for (int k = 0; k < LB_DEPTH; k++) begin
            if (li < 0 && ld_busy[(pick + k) % LB_DEPTH] &&
                    !ld[(pick + k) % LB_DEPTH].resolved) begin
                li = (pick + k) % LB_DEPTH;
            end
        end
        load_resolve_valid = li >= 0 && roll(drain ? 2 : 3) == 0;
        size   = mem_size_e'(roll(3));
        l_addr = rand_addr(size);
        load_resolve.lb_idx    = lb_idx_t'(li < 0 ? 0 : li);
        load_resolve.base      = $random(seed);
        load_resolve.offset    = l_addr - load_resolve.base;
        load_resolve.size      = size;
        load_resolve.is_signed = roll(2);
        load_resolve.dest_preg = PREG_W'(roll(64));
        load_resolve.rob_idx   = load_tag;

        // Cache store follows the commit within the cycle
        #1;
        retire = store_commit && st_count > 0 && st[st_head].resolved;
        if (cache_store_valid !== retire) begin
            value_error("cache_store_valid", cache_store_valid, retire);
        end else if (retire) begin
            exp_cs.addr    = st[st_head].addr;
            exp_cs.data    = st[st_head].data;
            exp_cs.size    = st[st_head].size;
            exp_cs.rob_idx = st[st_head].rob_idx;
            check_cache_store(cache_store, exp_cs);
        end

        if (store_resolve_valid && !st[ri].resolved) begin
            st[ri].resolved = 1'b1;
            st[ri].addr     = s_addr;
            st[ri].data     = store_resolve.data;
            st[ri].size     = store_resolve.size;
            st[ri].rob_idx  = store_resolve.rob_idx;
        end
        if (load_resolve_valid) begin
            ld[li].resolved  = 1'b1;
            ld[li].addr      = l_addr;
            ld[li].size      = load_resolve.size;
            ld[li].is_signed = load_resolve.is_signed;
            ld[li].dest_preg = load_resolve.dest_preg;
            ld[li].rob_idx   = load_tag;
            load_tag         = load_tag + 1'b1;
        end
        if (load_alloc) begin
            ld_busy[new_ld]     = 1'b1;
            ld_pending[new_ld]  = 1'b0;
            ld[new_ld].resolved = 1'b0;
            ld_seq[new_ld]      = st_total;
        end
        if (retire) begin
            st[st_head].resolved = 1'b0;
            st_head  = (st_head + 1) % SQ_DEPTH;
            st_count = st_count - 1;
        end
        if (store_alloc) begin
            tail = (st_head + st_count) % SQ_DEPTH;
            st[tail].resolved = 1'b0;
            st_seq[tail] = st_total;
            st_total = st_total + 1;
            st_count = st_count + 1;
        end
        mark_eligible();
    endtask

    task automatic step();
        collect_outputs();
        check_state();
        drive_cycle();
        @(negedge clock);
    endtask

    function automatic logic loads_busy();
        logic any;
        any = 1'b0;
        for (int j = 0; j < LB_DEPTH; j++) begin
            any = any | ld_busy[j];
        end
        return any;
    endfunction

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        store_alloc         = 1'b0;
        store_resolve_valid = 1'b0;
        store_resolve       = '0;
        store_commit        = 1'b0;
        load_alloc          = 1'b0;
        load_resolve_valid  = 1'b0;
        load_resolve        = '0;
        st_head  = 0;
        st_count = 0;
        st_total = 0;
        load_tag = '0;
        drain    = 1'b0;
        for (int i = 0; i < SQ_DEPTH; i++) begin
            st[i]     = '0;
            st_seq[i] = 0;
        end
        for (int j = 0; j < LB_DEPTH; j++) begin
            ld[j]         = '0;
            ld_busy[j]    = 1'b0;
            ld_pending[j] = 1'b0;
            ld_fwd[j]     = 1'b0;
            ld_seq[j]     = 0;
        end

        do begin
            @(negedge clock);
        end while (reset !== 1'b0);

        for (int n = 0; n < NUM_OPS; n++) begin
            step();
        end
        // Resolve and retire everything left over
        drain = 1'b1;
        while (st_count > 0 || loads_busy()) begin
            step();
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

    initial begin
        #(NUM_OPS * 40 * 8);
        $display("Watchdog expired because the run hung before all loads and stores finished");
        $display("CHECKS FAILED");
        $fatal(1, "watchdog timeout");
    end

endmodule

/* lsq.f */
lsq_pkg.sv
store_queue.sv
load_buffer.sv
store_forward.sv
lsq_top.sv
lsq_clock_gen.sv
lsq_tb.sv

/* Bender.yml */
package:
  name: lsq

sources:
  - lsq_pkg.sv
  - store_queue.sv
  - load_buffer.sv
  - store_forward.sv
  - lsq_top.sv
  - target: simulation
    files:
      - lsq_clock_gen.sv
      - lsq_tb.sv
